// ==== pwo.f ====
pwo_pkg.sv
pwo_mod_reduce.sv
pwo_lane.sv
pwo_ctrl.sv
pwo_top.sv
pwo_assertions.sv
tb_pwo.sv

// ==== pwo_assertions.sv ====
// ==========================================================
// Bound checker for the pointwise engine
// Result values, memory addresses, write timing and control
// ==========================================================

`timescale 1ns/1ps

module pwo_checker #(
    parameter int NUM_WORDS = 64
) (
    input logic               clk,
    input logic               reset_n,
    input logic               start_i,
    input pwo_pkg::pwo_mode_t mode_i,
    input logic               accumulate_i,
    input pwo_pkg::mem_addr_t a_base_i,
    input pwo_pkg::mem_addr_t b_base_i,
    input pwo_pkg::mem_addr_t c_base_i,
    input logic               a_rd_en_o,
    input pwo_pkg::mem_addr_t a_rd_addr_o,
    input logic               b_rd_en_o,
    input pwo_pkg::mem_addr_t b_rd_addr_o,
    input logic               c_rd_en_o,
    input pwo_pkg::mem_addr_t c_rd_addr_o,
    input logic               c_wr_en_o,
    input pwo_pkg::mem_addr_t c_wr_addr_o,
    input pwo_pkg::mem_word_t c_wr_data_o,
    input pwo_pkg::mem_word_t a_rd_data_i,
    input pwo_pkg::mem_word_t b_rd_data_i,
    input pwo_pkg::mem_word_t c_rd_data_i,
    input logic               busy_o,
    input logic               done_o
);
    import pwo_pkg::*;

    // Read data is this many cycles old when its result is written
    localparam int DLY = PIPE_DEPTH - 1;

    mem_word_t a_d [DLY];
    mem_word_t b_d [DLY];
    mem_word_t c_d [DLY];
    mem_word_t exp_word;
    pwo_mode_t mode_s;
    logic      acc_s;
    mem_addr_t a_base_s;
    mem_addr_t b_base_s;
    mem_addr_t c_base_s;
    logic      accept;
    logic      started;
    int        rd_count;
    int        wr_count;
    int        fail_count = 0;

    // A start only counts while the engine is idle
    assign accept = start_i && !busy_o;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            started  <= 1'b0;
            rd_count <= 0;
            wr_count <= 0;
            mode_s   <= PWO_MUL;
            acc_s    <= 1'b0;
            a_base_s <= '0;
            b_base_s <= '0;
            c_base_s <= '0;
            for (int i = 0; i < DLY; i++) begin
                a_d[i] <= '0;
                b_d[i] <= '0;
                c_d[i] <= '0;
            end
        end else begin
            if (start_i) started <= 1'b1;
            if (accept) begin
                mode_s   <= mode_i;
                acc_s    <= accumulate_i;
                a_base_s <= a_base_i;
                b_base_s <= b_base_i;
                c_base_s <= c_base_i;
                rd_count <= 0;
            end else if (a_rd_en_o) begin
                rd_count <= rd_count + 1;
            end
            if (done_o) wr_count <= 0;
            else if (c_wr_en_o) wr_count <= wr_count + 1;
            a_d[0] <= a_rd_data_i;
            b_d[0] <= b_rd_data_i;
            c_d[0] <= c_rd_data_i;
            for (int i = 1; i < DLY; i++) begin
                a_d[i] <= a_d[i-1];
                b_d[i] <= b_d[i-1];
                c_d[i] <= c_d[i-1];
            end
        end
    end

    function automatic longint lane_expect(input longint a, input longint b, input longint c,
                                           input pwo_mode_t m, input logic acc);
        longint q;
        q = longint'(MLDSA_Q);
        case (m)
            PWO_MUL: return (a * b + (acc ? c : 0)) % q;
            PWO_ADD: return (a + b) % q;
            default: return (a - b + q) % q;
        endcase
    endfunction

    always_comb begin
        exp_word = '0;
        for (int g = 0; g < LANES; g++) begin
            exp_word[g*LANE_W +: LANE_W] = LANE_W'(lane_expect(
                longint'(a_d[DLY-1][g*LANE_W +: COEFF_W]),
                longint'(b_d[DLY-1][g*LANE_W +: COEFF_W]),
                longint'(c_d[DLY-1][g*LANE_W +: COEFF_W]), mode_s, acc_s));
        end
    end

    a_reset_idle: assert property (@(posedge clk) disable iff (!reset_n)
        !started |-> !(a_rd_en_o || b_rd_en_o || c_rd_en_o || c_wr_en_o || busy_o || done_o))
        else begin
            fail_count++;
            $error("Port active before any start");
        end

    a_value: assert property (@(posedge clk) disable iff (!reset_n)
        c_wr_en_o |-> c_wr_data_o == exp_word)
        else begin
            fail_count++;
            $error("Fail at %0t ns: written word %h, expected %h",
                   $time, c_wr_data_o, exp_word);
        end

    a_c_read: assert property (@(posedge clk) disable iff (!reset_n)
        c_rd_en_o == (a_rd_en_o && mode_s == PWO_MUL && acc_s))
        else begin
            fail_count++;
            $error("c read enable does not match the mode taken at start");
        end

    a_rd_addr: assert property (@(posedge clk) disable iff (!reset_n)
        (a_rd_en_o || b_rd_en_o) |-> a_rd_en_o && b_rd_en_o && rd_count < NUM_WORDS
            && a_rd_addr_o == mem_addr_t'(a_base_s + rd_count)
            && b_rd_addr_o == mem_addr_t'(b_base_s + rd_count)
            && (!c_rd_en_o || c_rd_addr_o == mem_addr_t'(c_base_s + rd_count)))
        else begin
            fail_count++;
            $error("Fail at %0t ns: read request %0d has a wrong enable or address",
                   $time, rd_count);
        end

    a_wr_timing: assert property (@(posedge clk) disable iff (!reset_n)
        c_wr_en_o == $past(a_rd_en_o, PIPE_DEPTH))
        else begin
            fail_count++;
            $error("Write enable is not the read enable delayed");
        end

    a_wr_addr: assert property (@(posedge clk) disable iff (!reset_n)
        c_wr_en_o |-> wr_count < NUM_WORDS
            && c_wr_addr_o == mem_addr_t'(c_base_s + wr_count))
        else begin
            fail_count++;
            $error("Fail at %0t ns: write %0d went to address %h",
                   $time, wr_count, c_wr_addr_o);
        end

    a_done_pos: assert property (@(posedge clk) disable iff (!reset_n)
        done_o |-> $past(c_wr_en_o) && !c_wr_en_o && wr_count == NUM_WORDS)
        else begin
            fail_count++;
            $error("done is not right after the last of the pass writes");
        end

    a_done_end: assert property (@(posedge clk) disable iff (!reset_n)
        done_o |-> busy_o ##1 (!done_o && !busy_o))
        else begin
            fail_count++;
            $error("done is not a single pulse ending busy");
        end

    a_busy: assert property (@(posedge clk) disable iff (!reset_n)
        (a_rd_en_o || c_wr_en_o) |-> busy_o)
        else begin
            fail_count++;
            $error("busy is low while the pass is still running");
        end

    a_start_ok: assert property (@(posedge clk) disable iff (!reset_n)
        $rose(a_rd_en_o) |-> $past(start_i && !busy_o))
        else begin
            fail_count++;
            $error("Pass began without an accepted start");
        end

endmodule

bind pwo_top pwo_checker #(
    .NUM_WORDS (NUM_WORDS)
) chk_i (
    .clk          (clk),
    .reset_n      (reset_n),
    .start_i      (start_i),
    .mode_i       (mode_i),
    .accumulate_i (accumulate_i),
    .a_base_i     (a_base_i),
    .b_base_i     (b_base_i),
    .c_base_i     (c_base_i),
    .a_rd_en_o    (a_rd_en_o),
    .a_rd_addr_o  (a_rd_addr_o),
    .b_rd_en_o    (b_rd_en_o),
    .b_rd_addr_o  (b_rd_addr_o),
    .c_rd_en_o    (c_rd_en_o),
    .c_rd_addr_o  (c_rd_addr_o),
    .c_wr_en_o    (c_wr_en_o),
    .c_wr_addr_o  (c_wr_addr_o),
    .c_wr_data_o  (c_wr_data_o),
    .a_rd_data_i  (a_rd_data_i),
    .b_rd_data_i  (b_rd_data_i),
    .c_rd_data_i  (c_rd_data_i),
    .busy_o       (busy_o),
    .done_o       (done_o)
);

// ==== pwo_ctrl.sv ====
// ==========================================================
// Pointwise pass sequencer
// Issues NUM_WORDS reads, delays the write side, flags busy and done
// ==========================================================

`timescale 1ns/1ps

module pwo_ctrl #(
    parameter int NUM_WORDS = 64
) (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               start_i,
    input  pwo_pkg::pwo_mode_t mode_i,
    input  logic               accumulate_i,
    output pwo_pkg::pwo_mode_t mode_o,
    output logic               accumulate_o,
    output logic               rd_valid_o,
    output pwo_pkg::mem_addr_t rd_index_o,
    output logic               wr_valid_o,
    output pwo_pkg::mem_addr_t wr_index_o,
    output logic               busy_o,
    output logic               done_o
);
    import pwo_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READ,
        ST_DRAIN
    } state_t;

    localparam mem_addr_t LAST_INDEX = mem_addr_t'(NUM_WORDS - 1);

    state_t                state_q;
    logic                  start_ok;
    logic                  last_rd;
    logic                  last_wr;
    logic [PIPE_DEPTH-1:0] vld_sr;
    mem_addr_t             idx_sr [PIPE_DEPTH];

    // A start while a pass or its done cycle is pending is dropped
    assign start_ok = start_i && !busy_o;
    assign last_rd  = (state_q == ST_READ) && (rd_index_o == LAST_INDEX);

    // Last write is the one with nothing left behind it in the pipe
    assign last_wr  = (state_q == ST_DRAIN) && wr_valid_o && !(|vld_sr[PIPE_DEPTH-2:0]);

    // ==========================================================
    // Pass FSM
    // ==========================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q      <= ST_IDLE;
            rd_index_o   <= '0;
            mode_o       <= PWO_MUL;
            accumulate_o <= 1'b0;
            done_o       <= 1'b0;
        end else begin
            done_o <= last_wr;
            case (state_q)
                ST_IDLE: begin
                    if (start_ok) begin
                        state_q      <= ST_READ;
                        rd_index_o   <= '0;
                        mode_o       <= mode_i;
                        accumulate_o <= accumulate_i;
                    end
                end
                ST_READ: begin
                    if (last_rd) begin
                        state_q <= ST_DRAIN;
                    end else begin
                        rd_index_o <= rd_index_o + 1'b1;
                    end
                end
                ST_DRAIN: begin
                    if (last_wr) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    assign rd_valid_o = (state_q == ST_READ);
    assign busy_o     = (state_q != ST_IDLE) || done_o;

    // ==========================================================
    // Write side delay, matches memory plus lane latency
    // ==========================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            vld_sr <= '0;
        end else begin
            vld_sr <= {vld_sr[PIPE_DEPTH-2:0], rd_valid_o};
        end
    end

    always_ff @(posedge clk) begin
        idx_sr[0] <= rd_index_o;
        for (int i = 1; i < PIPE_DEPTH; i++) begin
            idx_sr[i] <= idx_sr[i-1];
        end
    end

    assign wr_valid_o = vld_sr[PIPE_DEPTH-1];
    assign wr_index_o = idx_sr[PIPE_DEPTH-1];

endmodule

// ==== pwo_lane.sv ====
// ==========================================================
// Pointwise coefficient lane
// Multiply, add or subtract modulo q with a fixed 3-cycle latency
// ==========================================================

`timescale 1ns/1ps

module pwo_lane (
    input  logic               clk,
    input  logic               reset_n,
    input  pwo_pkg::pwo_mode_t mode_i,
    input  logic               accumulate_i,
    input  pwo_pkg::coeff_t    a_i,
    input  pwo_pkg::coeff_t    b_i,
    input  pwo_pkg::coeff_t    c_i,
    output pwo_pkg::coeff_t    result_o
);
    import pwo_pkg::*;

    coeff_t a_q;
    coeff_t b_q;
    coeff_t c_q;
    wide_t  product;
    wide_t  addend;
    wide_t  pre_value;

    // Operand flops, these take the memory read data
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            a_q <= '0;
            b_q <= '0;
            c_q <= '0;
        end else begin
            a_q <= a_i;
            b_q <= b_i;
            c_q <= c_i;
        end
    end

    assign product = wide_t'(a_q) * wide_t'(b_q);
    assign addend  = accumulate_i ? wide_t'(c_q) : '0;

    // Every mode feeds the same reducer so the latency never depends on mode
    always_comb begin
        case (mode_i)
            PWO_MUL: begin
                pre_value = product + addend;
            end
            PWO_ADD: begin
                pre_value = wide_t'(a_q) + wide_t'(b_q);
            end
            PWO_SUB: begin
                // Adding q first keeps the difference positive
                pre_value = wide_t'(a_q) + wide_t'(MLDSA_Q) - wide_t'(b_q);
            end
            default: begin
                pre_value = '0;
            end
        endcase
    end

    pwo_mod_reduce u_reduce (
        .clk      (clk),
        .reset_n  (reset_n),
        .value_i  (pre_value),
        .result_o (result_o)
    );

endmodule

// ==== pwo_mod_reduce.sv ====
// ==========================================================
// Modular reduction by q for one lane
// Two-stage pipeline, takes any value below 2^47
// ==========================================================

`timescale 1ns/1ps

module pwo_mod_reduce (
    input  logic            clk,
    input  logic            reset_n,
    input  pwo_pkg::wide_t  value_i,
    output pwo_pkg::coeff_t result_o
);
    import pwo_pkg::*;

    // 2^23 is congruent to 2^13 - 1, so h * 2^23 + l folds to h * 2^13 - h + l
    logic [23:0] hi1;
    logic [22:0] lo1;
    logic [37:0] fold1;
    logic [14:0] hi2;
    logic [28:0] fold2;
    logic [28:0] part_q;
    logic [5:0]  hi3;
    logic [23:0] fold3;
    logic [23:0] sub_q;

    // Stage 1, two folds bring 47 bits down to 29
    assign hi1   = value_i[46:23];
    assign lo1   = value_i[22:0];
    assign fold1 = (38'(hi1) << 13) - 38'(hi1) + 38'(lo1);
    assign hi2   = fold1[37:23];
    assign fold2 = (29'(hi2) << 13) - 29'(hi2) + 29'(fold1[22:0]);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            part_q <= '0;
        end else begin
            part_q <= fold2;
        end
    end

    // Stage 2, last fold leaves a value below 2q
    assign hi3   = part_q[28:23];
    assign fold3 = (24'(hi3) << 13) - 24'(hi3) + 24'(part_q[22:0]);
    assign sub_q = fold3 - 24'(MLDSA_Q);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            result_o <= '0;
        end else if (fold3 >= 24'(MLDSA_Q)) begin
            result_o <= sub_q[COEFF_W-1:0];
        end else begin
            result_o <= fold3[COEFF_W-1:0];
        end
    end

endmodule

// ==== pwo_pkg.sv ====
// ==========================================================
// Pointwise engine package
// Modulus, lane geometry, pipeline depth and shared types
// ==========================================================

package pwo_pkg;

    // ML-DSA modulus, q = 2^23 - 2^13 + 1
    localparam int COEFF_W = 23;
    localparam logic [COEFF_W-1:0] MLDSA_Q = 23'd8380417;

    // Four coefficients per word, each in a 24-bit lane with a zero top bit
    localparam int LANE_W = 24;
    localparam int LANES  = 4;
    localparam int WORD_W = LANES * LANE_W;

    // Product of two coefficients plus one addend
    localparam int WIDE_W = 2 * COEFF_W + 1;

    localparam int ADDR_W = 15;

    // One cycle of memory read plus three cycles of lane pipeline
    localparam int PIPE_DEPTH = 4;

    typedef logic [COEFF_W-1:0] coeff_t;
    typedef logic [WIDE_W-1:0]  wide_t;
    typedef logic [WORD_W-1:0]  mem_word_t;
    typedef logic [ADDR_W-1:0]  mem_addr_t;

    // Pointwise operation select
    typedef enum logic [1:0] {
        PWO_MUL = 2'd0,
        PWO_ADD = 2'd1,
        PWO_SUB = 2'd2
    } pwo_mode_t;

endpackage

// ==== pwo_top.sv ====
// ==========================================================
// Pointwise coefficient engine, top level
// Steers the a, b and c memory ports and runs four lanes per word
// ==========================================================

`timescale 1ns/1ps

module pwo_top #(
    parameter int NUM_WORDS = 64
) (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               start_i,
    input  pwo_pkg::pwo_mode_t mode_i,
    input  logic               accumulate_i,
    input  pwo_pkg::mem_addr_t a_base_i,
    input  pwo_pkg::mem_addr_t b_base_i,
    input  pwo_pkg::mem_addr_t c_base_i,
    output logic               a_rd_en_o,
    output pwo_pkg::mem_addr_t a_rd_addr_o,
    output logic               b_rd_en_o,
    output pwo_pkg::mem_addr_t b_rd_addr_o,
    output logic               c_rd_en_o,
    output pwo_pkg::mem_addr_t c_rd_addr_o,
    input  pwo_pkg::mem_word_t a_rd_data_i,
    input  pwo_pkg::mem_word_t b_rd_data_i,
    input  pwo_pkg::mem_word_t c_rd_data_i,
    output logic               c_wr_en_o,
    output pwo_pkg::mem_addr_t c_wr_addr_o,
    output pwo_pkg::mem_word_t c_wr_data_o,
    output logic               busy_o,
    output logic               done_o
);
    import pwo_pkg::*;

    pwo_mode_t mode;
    logic      accumulate;
    logic      rd_valid;
    mem_addr_t rd_index;
    logic      wr_valid;
    mem_addr_t wr_index;
    mem_addr_t a_base_q;
    mem_addr_t b_base_q;
    mem_addr_t c_base_q;
    logic      c_read_on;
    coeff_t    lane_res [LANES];

    pwo_ctrl #(
        .NUM_WORDS (NUM_WORDS)
    ) u_ctrl (
        .clk          (clk),
        .reset_n      (reset_n),
        .start_i      (start_i),
        .mode_i       (mode_i),
        .accumulate_i (accumulate_i),
        .mode_o       (mode),
        .accumulate_o (accumulate),
        .rd_valid_o   (rd_valid),
        .rd_index_o   (rd_index),
        .wr_valid_o   (wr_valid),
        .wr_index_o   (wr_index),
        .busy_o       (busy_o),
        .done_o       (done_o)
    );

    // Bases are held for the pass, taken on an accepted start
    always_ff @(posedge clk) begin
        if (start_i && !busy_o) begin
            a_base_q <= a_base_i;
            b_base_q <= b_base_i;
            c_base_q <= c_base_i;
        end
    end

    // Only an accumulating multiply reads the old c word
    assign c_read_on = (mode == PWO_MUL) && accumulate;

    assign a_rd_en_o   = rd_valid;
    assign a_rd_addr_o = a_base_q + rd_index;
    assign b_rd_en_o   = rd_valid;
    assign b_rd_addr_o = b_base_q + rd_index;
    assign c_rd_en_o   = rd_valid && c_read_on;
    assign c_rd_addr_o = c_base_q + rd_index;

    assign c_wr_en_o   = wr_valid;
    assign c_wr_addr_o = c_base_q + wr_index;

    // Unpack each word into lanes, pack results back with the top bit clear
    for (genvar g = 0; g < LANES; g++) begin : g_lane
        pwo_lane u_lane (
            .clk          (clk),
            .reset_n      (reset_n),
            .mode_i       (mode),
            .accumulate_i (accumulate),
            .a_i          (a_rd_data_i[g*LANE_W +: COEFF_W]),
            .b_i          (b_rd_data_i[g*LANE_W +: COEFF_W]),
            .c_i          (c_read_on ? c_rd_data_i[g*LANE_W +: COEFF_W] : '0),
            .result_o     (lane_res[g])
        );

        assign c_wr_data_o[g*LANE_W +: LANE_W] = LANE_W'(lane_res[g]);
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the pointwise engine testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 --top-module tb_pwo -f pwo.f -o sim_pwo \
    > sim.log 2>&1 \
    && ./obj_dir/sim_pwo >> sim.log 2>&1
cat sim.log
grep -q "PASSED" sim.log && ! grep -q "\*\*\* FAILED \*\*\*" sim.log \
    && echo "Simulation passed" && exit 0 \
    || { echo "Simulation failed"; exit 1; }

// ==== tb_pwo.sv ====
// ==========================================================
// Testbench for the pointwise coefficient engine
// Memory models, xorshift data and a five-step test sequence
// ==========================================================

`timescale 1ns/1ps

module tb_pwo;
    import pwo_pkg::*;

    localparam int NUM_WORDS = 64;
    localparam int MEM_WORDS = 256;
    localparam int NUM_TESTS = 5;
    localparam int PASS_CYCLES = NUM_WORDS + PIPE_DEPTH + 20;
    localparam int CLK_PERIOD = 40;

    logic      clk;
    logic      reset_n;
    logic      start_i;
    pwo_mode_t mode_i;
    logic      accumulate_i;
    mem_addr_t a_base_i;
    mem_addr_t b_base_i;
    mem_addr_t c_base_i;
    logic      a_rd_en_o;
    mem_addr_t a_rd_addr_o;
    logic      b_rd_en_o;
    mem_addr_t b_rd_addr_o;
    logic      c_rd_en_o;
    mem_addr_t c_rd_addr_o;
    mem_word_t a_rd_data_i;
    mem_word_t b_rd_data_i;
    mem_word_t c_rd_data_i;
    logic      c_wr_en_o;
    mem_addr_t c_wr_addr_o;
    mem_word_t c_wr_data_o;
    logic      busy_o;
    logic      done_o;

    mem_word_t mem_a [MEM_WORDS];
    mem_word_t mem_b [MEM_WORDS];
    mem_word_t mem_c [MEM_WORDS];

    int        errors;
    int        passed;
    int        write_count;
    logic [31:0] rng;

    pwo_top #(
        .NUM_WORDS (NUM_WORDS)
    ) dut_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .start_i      (start_i),
        .mode_i       (mode_i),
        .accumulate_i (accumulate_i),
        .a_base_i     (a_base_i),
        .b_base_i     (b_base_i),
        .c_base_i     (c_base_i),
        .a_rd_en_o    (a_rd_en_o),
        .a_rd_addr_o  (a_rd_addr_o),
        .b_rd_en_o    (b_rd_en_o),
        .b_rd_addr_o  (b_rd_addr_o),
        .c_rd_en_o    (c_rd_en_o),
        .c_rd_addr_o  (c_rd_addr_o),
        .a_rd_data_i  (a_rd_data_i),
        .b_rd_data_i  (b_rd_data_i),
        .c_rd_data_i  (c_rd_data_i),
        .c_wr_en_o    (c_wr_en_o),
        .c_wr_addr_o  (c_wr_addr_o),
        .c_wr_data_o  (c_wr_data_o),
        .busy_o       (busy_o),
        .done_o       (done_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ==========================================================
    // Memory models, one-cycle registered read
    // ==========================================================
    always @(posedge clk) begin
        if (a_rd_en_o) a_rd_data_i <= mem_a[a_rd_addr_o[7:0]];
        if (b_rd_en_o) b_rd_data_i <= mem_b[b_rd_addr_o[7:0]];
        if (c_rd_en_o) c_rd_data_i <= mem_c[c_rd_addr_o[7:0]];
        // Write after the c read so a read always sees the old word
        if (c_wr_en_o) mem_c[c_wr_addr_o[7:0]] = c_wr_data_o;
    end

    // Writes are counted away from the rising edge
    always @(negedge clk) begin
        if (c_wr_en_o) write_count++;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic mem_word_t pack_word(input coeff_t c0, input coeff_t c1,
                                            input coeff_t c2, input coeff_t c3);
        return {1'b0, c3, 1'b0, c2, 1'b0, c1, 1'b0, c0};
    endfunction

    task automatic fill_memories();
        coeff_t c [12];
        coeff_t q_m1;
        coeff_t q_m2;
        q_m1 = MLDSA_Q - 23'd1;
        q_m2 = MLDSA_Q - 23'd2;
        for (int w = 0; w < MEM_WORDS; w++) begin
            for (int k = 0; k < 12; k++) begin
                rng  = xorshift(rng ^ 32'(w));
                c[k] = coeff_t'(rng % 32'(MLDSA_Q));
            end
            mem_a[w] = pack_word(c[0], c[1], c[2], c[3]);
            mem_b[w] = pack_word(c[4], c[5], c[6], c[7]);
            mem_c[w] = pack_word(c[8], c[9], c[10], c[11]);
        end
        // Edge values, including b above a for subtraction
        mem_a[0]  = pack_word(23'd0, q_m1, q_m1, 23'd0);
        mem_b[64] = pack_word(q_m1, q_m1, 23'd0, 23'd0);
        mem_a[1]  = pack_word(23'd1, 23'd5, 23'd0, q_m2);
        mem_b[65] = pack_word(23'd2, q_m1, 23'd1, q_m1);
    endtask

    task automatic run_pass(input string name, input pwo_mode_t mode, input logic acc,
                            input logic restart);
        int   cycles;
        int   fails_before;
        logic ok;
        fails_before = dut_i.chk_i.fail_count;
        ok           = 1'b1;
        write_count  = 0;
        mode_i       = mode;
        accumulate_i = acc;
        start_i      = 1'b1;
        @(posedge clk);
        #2;
        start_i = 1'b0;
        cycles  = 0;
        while (!done_o && cycles < PASS_CYCLES) begin
            @(posedge clk);
            #2;
            cycles++;
            // A start in the middle of a pass must be ignored
            if (restart && cycles == 10) begin
                start_i = 1'b1;
                mode_i  = PWO_ADD;
            end else begin
                start_i = 1'b0;
            end
        end
        if (!done_o) begin
            $display("Test %s: done never arrived within %0d cycles", name, PASS_CYCLES);
            ok = 1'b0;
        end else if (write_count != NUM_WORDS) begin
            $display("Fail at %0t ns: %s wrote %0d words, expected %0d",
                     $time, name, write_count, NUM_WORDS);
            ok = 1'b0;
        end
        repeat (3) @(posedge clk);
        #2;
        if (dut_i.chk_i.fail_count != fails_before) begin
            $display("Test %s: %0d assertion failures", name,
                     dut_i.chk_i.fail_count - fails_before);
            ok = 1'b0;
        end
        if (ok) begin
            $display("Test %s finished", name);
            passed++;
        end else begin
            $display("Test %s failed", name);
            errors++;
        end
    endtask

    initial begin
        errors       = 0;
        passed       = 0;
        write_count  = 0;
        rng          = 32'hb81a3db2;
        reset_n      = 1'b0;
        start_i      = 1'b0;
        mode_i       = PWO_MUL;
        accumulate_i = 1'b0;
        a_base_i     = 15'd0;
        b_base_i     = 15'd64;
        c_base_i     = 15'd128;
        a_rd_data_i  <= '0;
        b_rd_data_i  <= '0;
        c_rd_data_i  <= '0;
        fill_memories();
        repeat (8) @(posedge clk);
        #2;
        reset_n = 1'b1;

        // Idle after reset
        repeat (10) @(posedge clk);
        #2;
        if (dut_i.chk_i.fail_count == 0) begin
            $display("Test reset_idle finished");
            passed++;
        end else begin
            $display("Test reset_idle failed, a port was active before any start");
            errors++;
        end

        run_pass("multiply", PWO_MUL, 1'b0, 1'b0);
        run_pass("accumulate", PWO_MUL, 1'b1, 1'b0);
        run_pass("add", PWO_ADD, 1'b0, 1'b0);
        run_pass("subtract", PWO_SUB, 1'b0, 1'b1);

        $display("Tests passed: %0d, failed: %0d", passed, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Watchdog sized from the five tests with a margin of two
    initial begin
        #((2 * NUM_TESTS * PASS_CYCLES + 20) * CLK_PERIOD);
        $display("Timeout: the test sequence did not finish in time");
        $display("*** FAILED ***");
        $finish;
    end

endmodule
